//--- verilog.f
src/dcache_pkg.sv
src/way_if.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache.sv
tests/dcache_props.sv
tests/dcache_tb.sv

//--- tests/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    logic  CLK;
    logic  nRST;
    logic  halt;
    logic  mem_read;
    logic  mem_write;
    word_t addr;
    word_t wdata;
    logic  dhit;
    word_t rdata;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_wait;

    word_t rng;
    word_t wait_rng;
    word_t mem     [word_t];
    word_t ref_mem [word_t];

    // cache-content model
    logic  m_valid [2][NUM_SETS];
    logic  m_dirty [2][NUM_SETS];
    tag_t  m_tag   [2][NUM_SETS];
    logic  m_lru   [NUM_SETS];

    // completed transfers on the memory port
    logic  ev_wr   [$];
    word_t ev_addr [$];
    word_t ev_data [$];

    dcache UUT (.*);

    always #2 CLK = ~CLK;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t init_word(input word_t a);
        return (a * 32'h9e3779b1) ^ 32'h0bad_cafe;
    endfunction

    function automatic word_t mem_word(input word_t a);
        return mem.exists(a) ? mem[a] : init_word(a);
    endfunction

    function automatic word_t ref_word(input word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
    endfunction

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // memory model with random wait cycles
    always @(posedge CLK) begin
        if ((mem_ren || mem_wen) && !mem_wait) begin
            ev_wr.push_back(mem_wen);
            ev_addr.push_back(mem_addr);
            if (mem_wen) begin
                mem[mem_addr] = mem_wdata;
                ev_data.push_back(mem_wdata);
            end else begin
                ev_data.push_back(mem_rdata);
            end
        end
        #1;
        wait_rng  = xorshift(wait_rng);
        mem_wait  = nRST && (wait_rng[1:0] == 2'b00);
        mem_rdata = mem_ren ? mem_word(mem_addr) : '0;
    end

    task automatic expect_xfer(input logic wr, input word_t a, input word_t d);
        if (ev_addr.size() == 0) begin
            $display("memory %s of address %h never happened", wr ? "write" : "read", a);
            stop_failed();
        end
        check_eq("mem_wen", ev_wr.pop_front(), wr);
        check_eq("mem_addr", ev_addr.pop_front(), a);
        check_eq(wr ? "mem_wdata" : "mem_rdata", ev_data.pop_front(), d);
    endtask

    task automatic do_access(input logic is_wr, input word_t a, input word_t d);
        tag_t  t;
        idx_t  s;
        int    i;
        int    w;
        int    v;
        int    cycles;
        word_t base;
        t = a[31:6];
        s = a[5:3];
        w = -1;
        for (i = 0; i < 2; i++) begin
            if (m_valid[i][s] && m_tag[i][s] == t) begin
                w = i;
            end
        end
        mem_read  = !is_wr;
        mem_write = is_wr;
        addr      = a;
        wdata     = d;
        cycles    = 0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cycles > 200) begin
                $display("timed out waiting for dhit on address %h", a);
                stop_failed();
            end
        end while (!dhit);
        if (!is_wr) begin
            check_eq("rdata", rdata, ref_word(a));
        end
        if (w >= 0) begin
            check_eq("hit latency", cycles, 1);
            check_eq("mem_ren or mem_wen", mem_ren | mem_wen, 0);
        end else begin
            v = m_lru[s];
            // dirty victim goes out before the fill
            if (m_valid[v][s] && m_dirty[v][s]) begin
                base = {m_tag[v][s], s, 3'b000};
                expect_xfer(1'b1, base, ref_word(base));
                expect_xfer(1'b1, base + 4, ref_word(base + 4));
            end
            base = {t, s, 3'b000};
            expect_xfer(1'b0, base, ref_word(base));
            expect_xfer(1'b0, base + 4, ref_word(base + 4));
            m_tag[v][s]   = t;
            m_valid[v][s] = 1'b1;
            m_dirty[v][s] = 1'b0;
            w = v;
        end
        check_eq("extra memory transfers", ev_addr.size(), 0);
        m_lru[s] = (w == 0);
        if (is_wr) begin
            m_dirty[w][s] = 1'b1;
            ref_mem[a]    = d;
        end
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic run_flush();
        int    s;
        int    i;
        int    cycles;
        word_t base;
        halt   = 1'b1;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cycles > 200) begin
                $display("timed out waiting for flushed");
                stop_failed();
            end
        end while (!flushed);
        // sets in order, way 0 first
        for (s = 0; s < NUM_SETS; s++) begin
            for (i = 0; i < 2; i++) begin
                if (m_valid[i][s] && m_dirty[i][s]) begin
                    base = {m_tag[i][s], idx_t'(s), 3'b000};
                    expect_xfer(1'b1, base, ref_word(base));
                    expect_xfer(1'b1, base + 4, ref_word(base + 4));
                end
            end
        end
        check_eq("extra memory transfers", ev_addr.size(), 0);
        foreach (ref_mem[a]) begin
            check_eq("memory word", mem_word(a), ref_mem[a]);
        end
        // a clean line stays resident, so a read of it would hit in IDLE
        base = {24'h5c3a10, 8'h00};
        for (s = 0; s < NUM_SETS; s++) begin
            for (i = 0; i < 2; i++) begin
                if (m_valid[i][s] && !m_dirty[i][s]) begin
                    base = {m_tag[i][s], idx_t'(s), 3'b000};
                end
            end
        end
        #1;
        mem_read = 1'b1;
        addr     = base;
        repeat (4) begin
            @(posedge CLK);
            check_eq("flushed", flushed, 1);
            check_eq("dhit", dhit, 0);
        end
        check_eq("extra memory transfers", ev_addr.size(), 0);
        #1;
    endtask

    initial begin
        int    n;
        int    i;
        word_t r;
        CLK       = 1'b0;
        nRST      = 1'b0;
        halt      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        mem_rdata = '0;
        mem_wait  = 1'b0;
        rng       = 32'h8fe3;
        wait_rng  = xorshift(32'h8fe3);
        for (i = 0; i < NUM_SETS; i++) begin
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
            m_dirty[0][i] = 1'b0;
            m_dirty[1][i] = 1'b0;
            m_lru[i]      = 1'b0;
        end
        repeat (3) @(posedge CLK);
        #1;
        nRST = 1'b1;
        // four tags per set keep both ways busy
        for (n = 0; n < 400; n++) begin
            rng = xorshift(rng);
            r   = rng;
            rng = xorshift(rng);
            do_access(r[8], {24'h5c3a10, r[1:0], r[4:2], r[5], 2'b00}, rng);
        end
        run_flush();
        check_eq("assertion failures", UUT.ctrl.props.fail_count, 0);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- tests/dcache_props.sv
`timescale 1ns/10ps

module dcache_props (
    input logic              CLK,
    input logic              nRST,
    input logic              mem_ren,
    input logic              mem_wen,
    input logic              mem_wait,
    input logic              flushed,
    input dcache_pkg::word_t mem_addr,
    input dcache_pkg::word_t mem_wdata
);

    int fail_count = 0;

    // one memory request at a time
    no_dual_req: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin fail_count++; $error("mem_ren and mem_wen high together"); end

    word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) |-> (mem_addr[1:0] == 2'b00))
        else begin fail_count++; $error("mem_addr not word aligned"); end

    flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else begin fail_count++; $error("flushed dropped before reset"); end

    // stalled requests hold still
    ren_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren && mem_wait) |=> (mem_ren && $stable(mem_addr)))
        else begin fail_count++; $error("read request changed while mem_wait high"); end

    wen_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen && mem_wait) |=> (mem_wen && $stable(mem_addr) && $stable(mem_wdata)))
        else begin fail_count++; $error("write request changed while mem_wait high"); end

endmodule

bind dcache_ctrl dcache_props props (
    .CLK       (CLK),
    .nRST      (nRST),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_wait  (mem_wait),
    .flushed   (flushed),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
);

//--- src/dcache.sv
`timescale 1ns/10ps

module dcache (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              halt,
    input  logic              mem_read,
    input  logic              mem_write,
    input  dcache_pkg::word_t addr,
    input  dcache_pkg::word_t wdata,
    output logic              dhit,
    output dcache_pkg::word_t rdata,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::word_t mem_rdata,
    input  logic              mem_wait
);

    way_if way0_bus ();
    way_if way1_bus ();

    dcache_way way0 (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (way0_bus)
    );

    dcache_way way1 (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (way1_bus)
    );

    dcache_ctrl ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .way0      (way0_bus),
        .way1      (way1_bus),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .addr      (addr),
        .wdata     (wdata),
        .halt      (halt),
        .dhit      (dhit),
        .rdata     (rdata),
        .flushed   (flushed),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_wait  (mem_wait)
    );

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic              CLK,
    input  logic              nRST,
    way_if.ctrl               way0,
    way_if.ctrl               way1,
    input  logic              mem_read,
    input  logic              mem_write,
    input  dcache_pkg::word_t addr,
    input  dcache_pkg::word_t wdata,
    input  logic              halt,
    output logic              dhit,
    output dcache_pkg::word_t rdata,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::word_t mem_rdata,
    input  logic              mem_wait
);
    import dcache_pkg::*;

    cache_state_t          state;
    cache_state_t          next_state;
    logic [NUM_SETS-1:0]   lru;
    idx_t                  flush_set;

    tag_t                  req_tag;
    idx_t                  req_idx;
    logic [WORD_SEL_W-1:0] req_word;
    logic                  req;
    logic                  any_hit;
    logic                  victim;
    logic                  flush_way;
    logic                  flushing;
    logic                  mem_word;
    idx_t                  line_idx;
    logic [WORD_SEL_W-1:0] word_sel;

    logic                  sel_way;
    word_t                 sel_rdata;
    tag_t                  sel_tag;
    logic                  sel_valid;
    logic                  sel_dirty;

    logic                  wr_en;
    logic                  fill_tag;
    logic                  mark_dirty;
    logic                  clean;
    logic                  invalidate;
    word_t                 way_wdata;

    assign req_tag  = addr[WORD_W-1 -: TAG_W];
    assign req_idx  = addr[2+WORD_SEL_W +: IDX_W];
    assign req_word = addr[2 +: WORD_SEL_W];
    assign req      = mem_read | mem_write;
    assign any_hit  = way0.hit | way1.hit;
    // lru names the way to replace
    assign victim    = lru[req_idx];
    assign flush_way = ~way0.dirty;
    assign flushing  = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1, FLUSHED};
    assign mem_word  = state inside {WB_WORD1, FILL_WORD1, FLUSH_WB1};
    assign line_idx  = flushing ? flush_set : req_idx;
    assign word_sel  = (state == IDLE) ? req_word : WORD_SEL_W'(mem_word);

    // which way the current state works on
    always_comb begin
        case (state)
            IDLE:                                        sel_way = any_hit ? way1.hit : victim;
            FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1, FLUSHED:   sel_way = flush_way;
            default:                                     sel_way = victim;
        endcase
    end

    assign sel_rdata = sel_way ? way1.rdata    : way0.rdata;
    assign sel_tag   = sel_way ? way1.line_tag : way0.line_tag;
    assign sel_valid = sel_way ? way1.valid    : way0.valid;
    assign sel_dirty = sel_way ? way1.dirty    : way0.dirty;

    assign way0.idx        = line_idx;
    assign way1.idx        = line_idx;
    assign way0.tag        = req_tag;
    assign way1.tag        = req_tag;
    assign way0.word_sel   = word_sel;
    assign way1.word_sel   = word_sel;
    assign way0.wdata      = way_wdata;
    assign way1.wdata      = way_wdata;
    assign way0.wr_en      = wr_en & ~sel_way;
    assign way1.wr_en      = wr_en & sel_way;
    assign way0.fill_tag   = fill_tag & ~sel_way;
    assign way1.fill_tag   = fill_tag & sel_way;
    assign way0.mark_dirty = mark_dirty & ~sel_way;
    assign way1.mark_dirty = mark_dirty & sel_way;
    assign way0.clean      = clean & ~sel_way;
    assign way1.clean      = clean & sel_way;
    assign way0.invalidate = invalidate & ~sel_way;
    assign way1.invalidate = invalidate & sel_way;

    assign rdata   = sel_rdata;
    assign flushed = (state == FLUSHED);

    always_comb begin
        next_state = state;
        way_wdata  = wdata;
        wr_en      = 1'b0;
        fill_tag   = 1'b0;
        mark_dirty = 1'b0;
        clean      = 1'b0;
        invalidate = 1'b0;
        dhit       = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLUSH_SCAN;
                end else if (req && any_hit) begin
                    dhit = 1'b1;
                    if (mem_write) begin
                        wr_en      = 1'b1;
                        mark_dirty = 1'b1;
                    end
                end else if (req) begin
                    next_state = (sel_valid && sel_dirty) ? WB_WORD0 : FILL_WORD0;
                end
            end
            WB_WORD0, WB_WORD1, FLUSH_WB0, FLUSH_WB1: begin
                mem_wen   = 1'b1;
                mem_addr  = {sel_tag, line_idx, word_sel, 2'b00};
                mem_wdata = sel_rdata;
                if (!mem_wait) begin
                    case (state)
                        WB_WORD0:  next_state = WB_WORD1;
                        WB_WORD1:  next_state = FILL_WORD0;
                        FLUSH_WB0: next_state = FLUSH_WB1;
                        default: begin
                            clean      = 1'b1;
                            invalidate = 1'b1;
                            next_state = FLUSH_SCAN;
                        end
                    endcase
                end
            end
            FILL_WORD0, FILL_WORD1: begin
                mem_ren   = 1'b1;
                mem_addr  = {req_tag, req_idx, word_sel, 2'b00};
                way_wdata = mem_rdata;
                if (!mem_wait) begin
                    wr_en = 1'b1;
                    if (state == FILL_WORD0) begin
                        // old line is gone once its first word is replaced
                        invalidate = 1'b1;
                        next_state = FILL_WORD1;
                    end else begin
                        fill_tag   = 1'b1;
                        clean      = 1'b1;
                        next_state = IDLE;
                    end
                end
            end
            FLUSH_SCAN: begin
                if (way0.dirty || way1.dirty) begin
                    next_state = FLUSH_WB0;
                end else if (flush_set == IDX_W'(NUM_SETS - 1)) begin
                    next_state = FLUSHED;
                end
            end
            FLUSHED: begin
                next_state = FLUSHED;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            lru       <= '0;
            flush_set <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && halt) begin
                flush_set <= '0;
            end else if (state == FLUSH_SCAN && next_state == FLUSH_SCAN) begin
                flush_set <= flush_set + 1'b1;
            end
            // point lru away from the way just used
            if (dhit) begin
                lru[req_idx] <= ~way1.hit;
            end else if (state == FILL_WORD1 && !mem_wait) begin
                lru[req_idx] <= ~victim;
            end
        end
    end

endmodule

//--- src/dcache_way.sv
`timescale 1ns/10ps

module dcache_way (
    input logic CLK,
    input logic nRST,
    way_if.way  bus
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    tag_t                tag_q  [NUM_SETS];
    word_t               data_q [NUM_SETS][2**WORD_SEL_W];

    // combinational lookup of the addressed set
    assign bus.valid    = valid_q[bus.idx];
    assign bus.dirty    = dirty_q[bus.idx];
    assign bus.line_tag = tag_q[bus.idx];
    assign bus.hit      = valid_q[bus.idx] && (tag_q[bus.idx] == bus.tag);
    assign bus.rdata    = data_q[bus.idx][bus.word_sel];

    // line status bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (bus.invalidate) begin
                valid_q[bus.idx] <= 1'b0;
                dirty_q[bus.idx] <= 1'b0;
            end else begin
                if (bus.fill_tag) begin
                    valid_q[bus.idx] <= 1'b1;
                end
                if (bus.mark_dirty) begin
                    dirty_q[bus.idx] <= 1'b1;
                end else if (bus.clean) begin
                    dirty_q[bus.idx] <= 1'b0;
                end
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge CLK) begin
        if (bus.fill_tag) begin
            tag_q[bus.idx] <= bus.tag;
        end
        if (bus.wr_en) begin
            data_q[bus.idx][bus.word_sel] <= bus.wdata;
        end
    end

endmodule

//--- src/way_if.sv
`timescale 1ns/10ps

interface way_if;
    import dcache_pkg::*;

    // lookup and update controls
    idx_t                  idx;
    tag_t                  tag;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  wr_en;
    word_t                 wdata;
    logic                  fill_tag;
    logic                  mark_dirty;
    logic                  clean;
    logic                  invalidate;

    // state of the addressed line
    logic                  hit;
    logic                  valid;
    logic                  dirty;
    tag_t                  line_tag;
    word_t                 rdata;

    modport ctrl (
        output idx, tag, word_sel, wr_en, wdata, fill_tag, mark_dirty, clean, invalidate,
        input  hit, valid, dirty, line_tag, rdata
    );

    modport way (
        input  idx, tag, word_sel, wr_en, wdata, fill_tag, mark_dirty, clean, invalidate,
        output hit, valid, dirty, line_tag, rdata
    );

endinterface

//--- src/dcache_pkg.sv
package dcache_pkg;

    // address split is tag | index | word | byte
    localparam int WORD_W     = 32;
    localparam int TAG_W      = 26;
    localparam int IDX_W      = 3;
    localparam int NUM_SETS   = 8;
    localparam int WORD_SEL_W = 1;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  idx_t;

    typedef enum logic [3:0] {
        IDLE,
        WB_WORD0,
        WB_WORD1,
        FILL_WORD0,
        FILL_WORD1,
        FLUSH_SCAN,
        FLUSH_WB0,
        FLUSH_WB1,
        FLUSHED
    } cache_state_t;

endpackage
